//--- bench/tb_checker.sv
`timescale 1ns/10ps

module tb_checker (
    input  logic                clk,
    input  logic                rst,
    input  logic                cyc,
    input  logic                stb,
    input  logic                we,
    input  logic [1:0]          adr,
    input  logic [31:0]         dat_w,
    input  logic [31:0]         dat_r,
    input  logic                ack,
    input  conv_pkg::pix_beat_t pix,
    input  logic                pix_val,
    input  logic                pix_rdy,
    input  conv_pkg::acc_t      res,
    input  logic                res_val,
    input  logic                res_rdy,
    output int                  err_cnt
);

    // memory model filled in the order the bus hands over kernel words
    conv_pkg::kernel_word_t mem_model [conv_pkg::mem_depth];
    conv_pkg::mem_addr_t    wr_ptr;
    logic                   ptr_wrap;
    conv_pkg::mem_addr_t    wr_end;
    logic                   end_wrap;

    // current region and the column's position inside it
    conv_pkg::mem_addr_t rg_start;
    conv_pkg::mem_addr_t rg_stop;
    conv_pkg::mem_addr_t kidx;
    logic                region_seen;
    int                  bias;
    int                  acc;
    int                  prime_left;
    int                  exp_q [$];

    // the request seen before its ack, since the host drops stb in the ack cycle
    logic        req_live;
    logic        req_we;
    logic [1:0]  req_adr;
    logic [31:0] req_dat;

    logic           rst_q;
    logic           stall_seen;
    conv_pkg::acc_t stall_res;
    int             expv;

    initial err_cnt = 0;

    task automatic report_mismatch(input string name, input logic [31:0] want,
                                   input logic [31:0] got);
        $display("ERR %s expected %h actual %h at %0t", name, want, got, $time);
        err_cnt++;
    endtask

    task automatic report_failure(input string what);
        $display("failure: %s at %0t", what, $time);
        err_cnt++;
    endtask

    // full is the pointer on the end address with the two laps apart
    function automatic logic model_full();
        return (ptr_wrap != end_wrap) && (wr_ptr == wr_end);
    endfunction

    // sum over the four lanes of signed pixel times signed weight
    function automatic int lane_dot(input conv_pkg::kernel_word_t p,
                                    input conv_pkg::kernel_word_t w);
        int sum;
        sum = 0;
        for (int i = 0; i < conv_pkg::lane_nb; i++) begin
            sum += int'($signed(p[i*conv_pkg::lane_width +: conv_pkg::lane_width]))
                * int'($signed(w[i*conv_pkg::lane_width +: conv_pkg::lane_width]));
        end
        return sum;
    endfunction

    task automatic apply_access();
        logic [31:0] want;
        if (req_we) begin
            case (req_adr)
                conv_pkg::reg_data: begin
                    if (model_full()) begin
                        report_failure("a kernel word was taken while the memory was full");
                    end
                    mem_model[wr_ptr] = req_dat;
                    if (wr_ptr == conv_pkg::mem_addr_t'(conv_pkg::mem_depth - 1)) begin
                        ptr_wrap = ~ptr_wrap;
                    end
                    wr_ptr = wr_ptr + 4'd1;
                end
                conv_pkg::reg_wr_end: begin
                    // an end not above the old one frees space into the next lap
                    if (req_dat[conv_pkg::mem_awidth-1:0] <= wr_end) begin
                        end_wrap = ~end_wrap;
                    end
                    wr_end = req_dat[conv_pkg::mem_awidth-1:0];
                end
                conv_pkg::reg_rd_region: begin
                    rg_start = req_dat[conv_pkg::mem_awidth-1:0];
                    rg_stop = req_dat[16 +: conv_pkg::mem_awidth];
                    kidx = rg_start + 4'd1;
                    bias = int'($signed(mem_model[rg_start][conv_pkg::bias_width-1:0]));
                    acc = 0;
                    region_seen = 1'b1;
                    // pix_rdy stays low at this edge and the three after it
                    prime_left = 4;
                end
                default: begin
                end
            endcase
        end else begin
            case (req_adr)
                conv_pkg::reg_wr_end: want = {28'h0, wr_end};
                conv_pkg::reg_rd_region: want = {12'h0, rg_stop, 12'h0, rg_start};
                conv_pkg::reg_status: want = {31'h0, !model_full()};
                default: want = 32'h0;
            endcase
            if (dat_r !== want) begin
                report_mismatch("dat_r", want, dat_r);
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            if (rst_q === 1'b1 && (ack !== 1'b0 || res_val !== 1'b0 || pix_rdy !== 1'b0)) begin
                report_failure("ack, res_val or pix_rdy is not low in reset");
            end
            wr_ptr = '0;
            ptr_wrap = 1'b0;
            wr_end = '0;
            end_wrap = 1'b0;
            rg_start = '0;
            rg_stop = '0;
            kidx = '0;
            region_seen = 1'b0;
            bias = 0;
            acc = 0;
            prime_left = 0;
            exp_q.delete();
            req_live = 1'b0;
            stall_seen = 1'b0;
        end else begin
            // host bus first so a region change is in place for the checks below
            if (ack && req_live) begin
                apply_access();
                req_live = 1'b0;
            end
            if (cyc && stb && !ack) begin
                req_live = 1'b1;
                req_we = we;
                req_adr = adr;
                req_dat = dat_w;
            end

            if (!region_seen && pix_rdy) begin
                report_failure("pix_rdy rose before any region was set");
            end
            if (prime_left > 0) begin
                if (pix_rdy) begin
                    report_failure("pix_rdy was high while the column primed");
                end
                prime_left--;
            end

            // each accepted beat uses the next kernel word of the region
            if (pix_val && pix_rdy) begin
                acc += lane_dot(pix.data, mem_model[kidx]);
                kidx = (kidx == rg_stop) ? rg_start + 4'd1 : kidx + 4'd1;
                if (pix.last) begin
                    exp_q.push_back(bias + acc);
                    acc = 0;
                end
            end

            // a stalled result keeps both its valid and its value
            if (stall_seen) begin
                if (!res_val) begin
                    report_failure("res_val fell while the result was stalled");
                end else if (res !== stall_res) begin
                    report_mismatch("res", stall_res, res);
                end
            end
            stall_seen = res_val && !res_rdy;
            stall_res = res;

            if (res_val && res_rdy) begin
                if (exp_q.size() == 0) begin
                    report_failure("a result came out with no window pending");
                end else begin
                    expv = exp_q.pop_front();
                    if (res !== conv_pkg::acc_t'(expv)) begin
                        report_mismatch("res", conv_pkg::acc_t'(expv), res);
                    end
                end
            end
        end
        rst_q = rst;
    end

endmodule

//--- bench/tb_conv.sv
`timescale 1ns/10ps

module tb_conv;

    // longest wait in cycles before a handshake counts as lost
    localparam int wait_limit = 200;

    logic                   clk;
    logic                   rst;
    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic [1:0]             adr;
    logic [31:0]            dat_w;
    logic [31:0]            dat_r;
    logic                   ack;
    conv_pkg::pix_beat_t    pix;
    logic                   pix_val;
    logic                   pix_rdy;
    conv_pkg::acc_t         res;
    logic                   res_val;
    logic                   res_rdy;

    logic [31:0]            seed;
    logic [31:0]            rdy_state;
    int                     chk_cnt;
    int                     tmo_cnt;
    int                     win_sent;
    int                     res_got;
    conv_pkg::mem_addr_t    cur_end;

    conv_top DUT (
        .clk     (clk),
        .rst     (rst),
        .cyc     (cyc),
        .stb     (stb),
        .we      (we),
        .adr     (adr),
        .dat_w   (dat_w),
        .dat_r   (dat_r),
        .ack     (ack),
        .pix     (pix),
        .pix_val (pix_val),
        .pix_rdy (pix_rdy),
        .res     (res),
        .res_val (res_val),
        .res_rdy (res_rdy)
    );

    tb_checker u_chk (
        .clk     (clk),
        .rst     (rst),
        .cyc     (cyc),
        .stb     (stb),
        .we      (we),
        .adr     (adr),
        .dat_w   (dat_w),
        .dat_r   (dat_r),
        .ack     (ack),
        .pix     (pix),
        .pix_val (pix_val),
        .pix_rdy (pix_rdy),
        .res     (res),
        .res_val (res_val),
        .res_rdy (res_rdy),
        .err_cnt (chk_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // the main stimulus stream steps its own state
    function automatic logic [31:0] next_rand();
        seed = xorshift(seed);
        return seed;
    endfunction

    // results handed over at an edge are counted so the run knows when a window is done
    always @(posedge clk) begin
        if (rst) begin
            res_got <= 0;
        end else if (res_val && res_rdy) begin
            res_got <= res_got + 1;
        end
    end

    // the result sink stalls about one cycle in four from a stream of its own
    initial begin
        rdy_state = ~32'hecb7_faa3;
        res_rdy = 1'b0;
        forever begin
            @(negedge clk);
            rdy_state = xorshift(rdy_state);
            res_rdy = (rdy_state[1:0] != 2'b00);
        end
    end

    // one classic cycle held until ack, then one idle cycle before the next one
    task automatic bus_access(input logic write, input logic [1:0] addr,
                              input logic [31:0] data, output logic [31:0] rdata);
        int waited;
        cyc = 1'b1;
        stb = 1'b1;
        we = write;
        adr = addr;
        dat_w = data;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!ack && waited < wait_limit);
        rdata = dat_r;
        if (!ack) begin
            $display("timeout: bus access to register %0d got no ack at %0t", addr, $time);
            tmo_cnt++;
        end
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        @(negedge clk);
    endtask

    task automatic bus_write(input logic [1:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        bus_access(1'b1, addr, data, unused);
    endtask

    // the value read is judged by the checker, which sees the same bus
    task automatic bus_read(input logic [1:0] addr);
        logic [31:0] unused;
        bus_access(1'b0, addr, 32'h0, unused);
    endtask

    // a beat waits up to two idle cycles, then is held until the column takes it
    task automatic send_beat(input conv_pkg::kernel_word_t data, input logic last);
        int gap;
        int waited;
        gap = int'(next_rand() % 3);
        pix_val = 1'b0;
        repeat (gap) @(negedge clk);
        pix.data = data;
        pix.last = last;
        pix_val = 1'b1;
        waited = 0;
        while (!pix_rdy && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!pix_rdy) begin
            $display("timeout: a pixel beat was never accepted at %0t", $time);
            tmo_cnt++;
        end
        @(negedge clk);
        pix_val = 1'b0;
    endtask

    task automatic send_window();
        int beats;
        beats = 1 + int'(next_rand() % 6);
        for (int b = 1; b <= beats; b++) begin
            send_beat(next_rand(), b == beats);
        end
        win_sent++;
    endtask

    task automatic wait_results();
        int waited;
        waited = 0;
        while (res_got != win_sent && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (res_got != win_sent) begin
            $display("timeout: only %0d of %0d results arrived", res_got, win_sent);
            tmo_cnt++;
        end
    endtask

    initial begin
        logic [31:0] rnd;
        int          k;
        int          start;
        int          stop;
        int          nwin;
        seed = 32'hecb7_faa3;
        rst = 1'b1;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = 2'd0;
        dat_w = 32'h0;
        pix = '0;
        pix_val = 1'b0;
        tmo_cnt = 0;
        win_sent = 0;
        cur_end = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // a fresh memory has room, and sixteen words fill it up
        bus_read(conv_pkg::reg_status);
        repeat (conv_pkg::mem_depth) begin
            bus_write(conv_pkg::reg_data, next_rand());
            bus_read(conv_pkg::reg_status);
        end
        bus_read(conv_pkg::reg_data);

        for (int round = 0; round < 12; round++) begin
            // free k words past the old end, with junk above the end field
            k = 1 + int'(next_rand() % 6);
            cur_end = cur_end + conv_pkg::mem_addr_t'(k);
            rnd = next_rand();
            bus_write(conv_pkg::reg_wr_end, {rnd[31:4], cur_end});
            bus_read(conv_pkg::reg_wr_end);
            bus_read(conv_pkg::reg_status);
            repeat (k) bus_write(conv_pkg::reg_data, next_rand());
            bus_read(conv_pkg::reg_status);

            // a forward region somewhere in the ring, junk outside its two fields
            start = int'(next_rand() % 15);
            stop = start + 1 + int'(next_rand() % (15 - start));
            rnd = next_rand();
            bus_write(conv_pkg::reg_rd_region,
                      {rnd[31:20], stop[3:0], rnd[15:4], start[3:0]});
            bus_read(conv_pkg::reg_rd_region);

            nwin = 1 + int'(next_rand() % 3);
            repeat (nwin) send_window();
            wait_results();
        end

        repeat (4) @(negedge clk);
        $display("closing counts: %0d check errors, %0d timeouts", chk_cnt, tmo_cnt);
        if (chk_cnt == 0 && tmo_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // every wait above is bounded, this only catches a run that stops making progress
    initial begin
        #5000000;
        $display("timeout: the run did not reach its end in time");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log for the fail message

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        -f vlog.f --top-module tb_conv -o tb_conv; then
    echo "build failed"
    exit 1
fi

if ! ./obj_dir/tb_conv > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi

cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    exit 1
fi

exit 0

//--- verilog/conv_column.sv
`timescale 1ns/10ps

module conv_column (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rd_cfg_set,
    input  conv_pkg::kernel_word_t rd_data,
    input  conv_pkg::kernel_word_t rd_bias,
    output logic                   rd_data_rdy,
    input  conv_pkg::pix_beat_t    pix,
    input  logic                   pix_val,
    output logic                   pix_rdy,
    output conv_pkg::acc_t         res,
    output logic                   res_val,
    input  logic                   res_rdy
);

    conv_pkg::col_state_t state;
    logic [1:0]           prime_cnt;
    logic                 cfg_valid;
    logic                 beat_ok;
    conv_pkg::acc_t       acc;
    conv_pkg::acc_t       dot;
    conv_pkg::acc_t       bias;
    logic signed [2*conv_pkg::lane_width-1:0] prod [conv_pkg::lane_nb];

    // beats are refused while a region change is on the wires so no beat meets a stale kernel
    assign pix_rdy = (state == conv_pkg::col_run) && !rd_cfg_set;
    assign beat_ok = pix_val && pix_rdy;
    assign res_val = (state == conv_pkg::col_hold);

    // each accepted beat uses up one kernel word
    assign rd_data_rdy = beat_ok;

    // signed lane products summed into one dot product for this beat
    always_comb begin
        dot = '0;
        for (int i = 0; i < conv_pkg::lane_nb; i++) begin
            prod[i] = conv_pkg::lane_t'(pix.data[i*conv_pkg::lane_width +: conv_pkg::lane_width])
                * conv_pkg::lane_t'(rd_data[i*conv_pkg::lane_width +: conv_pkg::lane_width]);
            dot = dot + conv_pkg::acc_t'(prod[i]);
        end
    end

    // the bias lives sign extended in the low half of the bias word
    assign bias = conv_pkg::acc_t'($signed(rd_bias[conv_pkg::bias_width-1:0]));

    // prime_cnt covers the memory priming pops and the bias latch after a region change
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= conv_pkg::col_prime;
            prime_cnt <= '0;
            cfg_valid <= 1'b0;
        end else begin
            if (rd_cfg_set) begin
                prime_cnt <= 2'd2;
                cfg_valid <= 1'b1;
            end else if (prime_cnt != 2'd0) begin
                prime_cnt <= prime_cnt - 2'd1;
            end
            case (state)
                conv_pkg::col_prime: begin
                    // nothing runs until a region has been set at least once
                    if (cfg_valid && (prime_cnt == 2'd0) && !rd_cfg_set) begin
                        state <= conv_pkg::col_run;
                    end
                end
                conv_pkg::col_run: begin
                    if (rd_cfg_set) begin
                        state <= conv_pkg::col_prime;
                    end else if (beat_ok && pix.last) begin
                        state <= conv_pkg::col_hold;
                    end
                end
                conv_pkg::col_hold: begin
                    // a region change seen while holding still primes once the result is taken
                    if (res_rdy) begin
                        if (rd_cfg_set || (prime_cnt != 2'd0)) begin
                            state <= conv_pkg::col_prime;
                        end else begin
                            state <= conv_pkg::col_run;
                        end
                    end
                end
                default: state <= conv_pkg::col_prime;
            endcase
        end
    end

    // the running sum restarts after every window and on every region change
    always_ff @(posedge clk) begin
        if (rst || rd_cfg_set) begin
            acc <= '0;
        end else if (beat_ok) begin
            acc <= pix.last ? '0 : acc + dot;
        end
    end

    // the result is formed on the last beat and then sits still until taken
    always_ff @(posedge clk) begin
        if (beat_ok && pix.last) begin
            res <= bias + acc + dot;
        end
    end

    // a stalled result keeps both its valid and its value
    a_res_hold: assert property (@(posedge clk) disable iff (rst)
        (res_val && !res_rdy) |=> (res_val && $stable(res)));

    // no beat is taken while the memory primes the new region
    a_prime_gap: assert property (@(posedge clk) disable iff (rst)
        rd_cfg_set |=> (!pix_rdy) [*3]);

endmodule

//--- verilog/conv_pkg.sv
package conv_pkg;

    // the kernel memory holds sixteen packed kernel words
    localparam int mem_awidth = 4;
    localparam int mem_depth = 1 << mem_awidth;

    // four signed lanes per word stand for two groups of two depths
    localparam int lane_nb = 4;
    localparam int lane_width = 8;
    localparam int word_width = lane_nb * lane_width;

    // the accumulator leaves headroom over the sum of many lane products
    localparam int acc_width = 24;

    // only the low half of the bias word carries the bias value
    localparam int bias_width = 16;

    // word addresses of the host registers
    localparam logic [1:0] reg_data = 2'd0;
    localparam logic [1:0] reg_wr_end = 2'd1;
    localparam logic [1:0] reg_rd_region = 2'd2;
    localparam logic [1:0] reg_status = 2'd3;

    typedef logic [mem_awidth-1:0] mem_addr_t;
    typedef logic [word_width-1:0] kernel_word_t;
    typedef logic signed [lane_width-1:0] lane_t;
    typedef logic signed [acc_width-1:0] acc_t;

    // one beat of pixels with lane 0 in the low bits of data
    typedef struct packed {
        kernel_word_t data;
        logic         last;
    } pix_beat_t;

    // the region start holds the bias and stop is the last kernel word read
    typedef struct packed {
        mem_addr_t start;
        mem_addr_t stop;
    } rd_region_t;

    typedef enum logic [1:0] {col_prime, col_run, col_hold} col_state_t;

endpackage

//--- verilog/conv_top.sv
`timescale 1ns/10ps

module conv_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                cyc,
    input  logic                stb,
    input  logic                we,
    input  logic [1:0]          adr,
    input  logic [31:0]         dat_w,
    output logic [31:0]         dat_r,
    output logic                ack,
    input  conv_pkg::pix_beat_t pix,
    input  logic                pix_val,
    output logic                pix_rdy,
    output conv_pkg::acc_t      res,
    output logic                res_val,
    input  logic                res_rdy
);

    // write side between the register block and the kernel memory
    conv_pkg::mem_addr_t    wr_cfg_end;
    logic                   wr_cfg_set;
    conv_pkg::kernel_word_t wr_data;
    logic                   wr_data_val;
    logic                   wr_data_rdy;

    // read region setup shared by the memory and the column
    conv_pkg::rd_region_t   rd_cfg;
    logic                   rd_cfg_set;

    // kernel words and bias handed from memory to the column
    conv_pkg::kernel_word_t rd_bias;
    conv_pkg::kernel_word_t rd_data;
    logic                   rd_data_rdy;

    kernel_cfg_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .cyc         (cyc),
        .stb         (stb),
        .we          (we),
        .adr         (adr),
        .dat_w       (dat_w),
        .dat_r       (dat_r),
        .ack         (ack),
        .wr_cfg_end  (wr_cfg_end),
        .wr_cfg_set  (wr_cfg_set),
        .wr_data     (wr_data),
        .wr_data_val (wr_data_val),
        .wr_data_rdy (wr_data_rdy),
        .rd_cfg      (rd_cfg),
        .rd_cfg_set  (rd_cfg_set)
    );

    kernel_mem u_mem (
        .clk         (clk),
        .rst         (rst),
        .wr_cfg_end  (wr_cfg_end),
        .wr_cfg_set  (wr_cfg_set),
        .wr_data     (wr_data),
        .wr_data_val (wr_data_val),
        .wr_data_rdy (wr_data_rdy),
        .rd_cfg      (rd_cfg),
        .rd_cfg_set  (rd_cfg_set),
        .rd_bias     (rd_bias),
        .rd_data     (rd_data),
        .rd_data_rdy (rd_data_rdy)
    );

    // a single column is fed from the memory in this slice
    conv_column u_col (
        .clk         (clk),
        .rst         (rst),
        .rd_cfg_set  (rd_cfg_set),
        .rd_data     (rd_data),
        .rd_bias     (rd_bias),
        .rd_data_rdy (rd_data_rdy),
        .pix         (pix),
        .pix_val     (pix_val),
        .pix_rdy     (pix_rdy),
        .res         (res),
        .res_val     (res_val),
        .res_rdy     (res_rdy)
    );

endmodule

//--- verilog/kernel_cfg_regs.sv
`timescale 1ns/10ps

module kernel_cfg_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cyc,
    input  logic                   stb,
    input  logic                   we,
    input  logic [1:0]             adr,
    input  logic [31:0]            dat_w,
    output logic [31:0]            dat_r,
    output logic                   ack,
    output conv_pkg::mem_addr_t    wr_cfg_end,
    output logic                   wr_cfg_set,
    output conv_pkg::kernel_word_t wr_data,
    output logic                   wr_data_val,
    input  logic                   wr_data_rdy,
    output conv_pkg::rd_region_t   rd_cfg,
    output logic                   rd_cfg_set
);

    logic        access;
    logic        wr_access;
    logic        data_done;
    logic [31:0] rd_word;

    // a strobe is only served while ack is low so every access acts once
    assign access = cyc && stb && !ack;
    assign wr_access = access && we;

    // the kernel word is pushed straight from the bus and held there until the memory takes it
    assign wr_data_val = wr_access && (adr == conv_pkg::reg_data);
    assign wr_data = dat_w;
    assign data_done = !wr_data_val || wr_data_rdy;

    // a full memory holds back ack and so stalls the host
    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
        end else begin
            ack <= access && data_done;
        end
    end

    // configuration writes store the field and fire a one cycle pulse with it
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_cfg_end <= '0;
            wr_cfg_set <= 1'b0;
            rd_cfg <= '0;
            rd_cfg_set <= 1'b0;
        end else begin
            wr_cfg_set <= wr_access && (adr == conv_pkg::reg_wr_end);
            rd_cfg_set <= wr_access && (adr == conv_pkg::reg_rd_region);
            if (wr_access && (adr == conv_pkg::reg_wr_end)) begin
                wr_cfg_end <= dat_w[conv_pkg::mem_awidth-1:0];
            end
            if (wr_access && (adr == conv_pkg::reg_rd_region)) begin
                rd_cfg.start <= dat_w[conv_pkg::mem_awidth-1:0];
                rd_cfg.stop <= dat_w[16 +: conv_pkg::mem_awidth];
            end
        end
    end

    // the data register is write only and reads back as zero
    always_comb begin
        rd_word = '0;
        case (adr)
            conv_pkg::reg_wr_end: rd_word[conv_pkg::mem_awidth-1:0] = wr_cfg_end;
            conv_pkg::reg_rd_region: begin
                rd_word[conv_pkg::mem_awidth-1:0] = rd_cfg.start;
                rd_word[16 +: conv_pkg::mem_awidth] = rd_cfg.stop;
            end
            conv_pkg::reg_status: rd_word[0] = wr_data_rdy;
            default: rd_word = '0;
        endcase
    end

    // read data is captured on the edge that raises ack
    always_ff @(posedge clk) begin
        if (access && !we) begin
            dat_r <= rd_word;
        end
    end

    // the slave always leaves a gap between two acknowledges
    a_ack_gap: assert property (@(posedge clk) disable iff (rst) ack |=> !ack);

endmodule

//--- verilog/kernel_mem.sv
`timescale 1ns/10ps

module kernel_mem (
    input  logic                   clk,
    input  logic                   rst,
    input  conv_pkg::mem_addr_t    wr_cfg_end,
    input  logic                   wr_cfg_set,
    input  conv_pkg::kernel_word_t wr_data,
    input  logic                   wr_data_val,
    output logic                   wr_data_rdy,
    input  conv_pkg::rd_region_t   rd_cfg,
    input  logic                   rd_cfg_set,
    output conv_pkg::kernel_word_t rd_bias,
    output conv_pkg::kernel_word_t rd_data,
    input  logic                   rd_data_rdy
);

    conv_pkg::kernel_word_t mem [conv_pkg::mem_depth];

    conv_pkg::mem_addr_t wr_ptr;
    logic                wr_ptr_wrap;
    conv_pkg::mem_addr_t wr_end;
    logic                wr_end_wrap;
    logic                wr_push;
    logic [conv_pkg::mem_awidth:0] wr_free;

    logic                prime_1st;
    logic                prime_2nd;
    logic                prime_3rd;
    logic                rd_pop;
    conv_pkg::mem_addr_t rd_ptr;
    conv_pkg::mem_addr_t rd_base;
    conv_pkg::mem_addr_t rd_stop;

    // the ring is full when the pointer sits on the end address one lap behind it
    assign wr_data_rdy = !((wr_ptr_wrap != wr_end_wrap) && (wr_ptr == wr_end));
    assign wr_push = wr_data_val && wr_data_rdy;

    // free words from the pointer up to the end, which is a lap ahead when the wraps match
    assign wr_free = {~wr_end_wrap, wr_end} - {wr_ptr_wrap, wr_ptr};

    // out of reset the end sits a whole lap ahead of the pointer so all sixteen words are free
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_end <= '0;
            wr_end_wrap <= 1'b0;
        end else if (wr_cfg_set) begin
            wr_end <= wr_cfg_end;
            // an end at or below the old one means the free space runs past the top of memory
            if (wr_cfg_end <= wr_end) begin
                wr_end_wrap <= ~wr_end_wrap;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            wr_ptr_wrap <= 1'b0;
        end else if (wr_push) begin
            wr_ptr <= wr_ptr + 1'b1;
            if (wr_ptr == conv_pkg::mem_addr_t'(conv_pkg::mem_depth - 1)) begin
                wr_ptr_wrap <= ~wr_ptr_wrap;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // a new region primes with two pops
    // the first steps over the bias word and the second puts the first kernel word on rd_data
    // the third stage latches the bias once the kernel word is already out
    always_ff @(posedge clk) begin
        if (rst) begin
            prime_1st <= 1'b0;
            prime_2nd <= 1'b0;
            prime_3rd <= 1'b0;
        end else begin
            prime_1st <= rd_cfg_set;
            prime_2nd <= prime_1st && !rd_cfg_set;
            prime_3rd <= prime_2nd && !rd_cfg_set;
        end
    end

    assign rd_pop = prime_1st || prime_2nd || rd_data_rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_base <= '0;
            rd_stop <= '0;
            rd_ptr <= '0;
        end else if (rd_cfg_set) begin
            rd_base <= rd_cfg.start;
            rd_stop <= rd_cfg.stop;
            rd_ptr <= rd_cfg.start;
        end else if (rd_pop) begin
            // the region stop wins over the top of memory
            // past the top the 4 bit pointer rolls over to zero by itself
            if (rd_ptr == rd_stop) begin
                rd_ptr <= rd_base + 1'b1;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_pop) begin
            rd_data <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (prime_3rd) begin
            rd_bias <= mem[rd_base];
        end
    end

    // in a forward region the read pointer never leaves start to stop
    a_rd_in_region: assert property (@(posedge clk) disable iff (rst)
        (rd_base < rd_stop) |-> ((rd_ptr >= rd_base) && (rd_ptr <= rd_stop)));

    // the write pointer never runs more than one whole ring behind the write end
    a_wr_in_range: assert property (@(posedge clk) disable iff (rst)
        wr_free <= conv_pkg::mem_depth);

    // the bias only moves in the few cycles after a region change
    a_bias_stable: assert property (@(posedge clk) disable iff (rst)
        (!$past(rd_cfg_set, 1) && !$past(rd_cfg_set, 2) && !$past(rd_cfg_set, 3)
            && !$past(rd_cfg_set, 4) && !$isunknown($past(rd_bias)))
        |-> $stable(rd_bias));

    // space only runs out because a word was pushed
    a_rdy_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(wr_data_rdy) |-> $past(wr_push));

endmodule

//--- vlog.f
verilog/conv_pkg.sv
verilog/kernel_mem.sv
verilog/kernel_cfg_regs.sv
verilog/conv_column.sv
verilog/conv_top.sv
bench/tb_checker.sv
bench/tb_conv.sv
